/* project.f */
+incdir+bench
verilog/video_pkg.sv
verilog/bus_pkg.sv
verilog/gfx_ram.sv
verilog/vid_timing.sv
verilog/tile_layer.sv
verilog/obj_layer.sv
verilog/pix_mixer.sv
verilog/board_video.sv
bench/board_video_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the board video testbench with Verilator.
# The run fails when the build or the simulation breaks, or
# when the log holds the failure line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert \
    -f project.f --top-module board_video_tb -o board_video_sim \
    && ./obj_dir/board_video_sim > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat "$LOG"
grep -q "Regression failed" "$LOG" && exit 1 || exit 0

/* bench/video_ref.svh */
// **********************************************************
// Reference model for the board video testbench. Holds a
// shadow of every word written over the CPU bus, indexed
// by bus address, and gives the expected RGB for a screen
// position. Included inside the testbench module.
// **********************************************************
`ifndef VIDEO_REF_SVH
`define VIDEO_REF_SVH

// Unmapped addresses stay zero, as the bus reads them
data_t shadow [2 ** bus_pkg::ADDR_W];

function automatic void shadow_clear();
    for (int a = 0; a < 2 ** bus_pkg::ADDR_W; a++) begin
        shadow[addr_t'(a)] = '0;
    end
endfunction

// Keeps only the bits that each region stores
function automatic void shadow_write(input addr_t addr, input data_t data);
    int off;
    off = int'(addr);
    if (off >= int'(bus_pkg::TILE_BASE) && off < int'(bus_pkg::TILE_BASE) + TILE_N) begin
        shadow[addr] = data_t'(data[$bits(bus_pkg::tile_entry_t)-1:0]);
    end else if (off >= int'(bus_pkg::OBJ_BASE) && off < int'(bus_pkg::OBJ_BASE) + OBJ_N) begin
        shadow[addr] = data;
    end else if (off >= int'(bus_pkg::PAL_BASE) && off < int'(bus_pkg::PAL_BASE) + PAL_N) begin
        shadow[addr] = data_t'(data[$bits(video_pkg::rgb_t)-1:0]);
    end
endfunction

function automatic video_pkg::rgb_t expected_rgb(input int col, input int row);
    bus_pkg::tile_entry_t tile;
    bus_pkg::obj_entry_t  obj;
    logic [1:0]           quad;
    logic                 tile_on;
    logic                 obj_on;
    logic                 obj_top;
    logic [3:0]           obj_colour;
    video_pkg::pal_idx_t  idx;
    tile = shadow[addr_t'(int'(bus_pkg::TILE_BASE) + (row / TS) * COLS + col / TS)]
        [$bits(bus_pkg::tile_entry_t)-1:0];
    quad[1] = (row % TS) >= TS / 2;
    quad[0] = (col % TS) >= TS / 2;
    tile_on = tile.mask[quad];
    obj_on = 1'b0;
    obj_top = 1'b0;
    obj_colour = '0;
    // First enabled hit counting up is the winner
    for (int i = 0; i < OBJ_N; i++) begin
        obj = shadow[addr_t'(int'(bus_pkg::OBJ_BASE) + i)];
        if (!obj_on && obj.en && col >= int'(obj.x) && col < int'(obj.x) + TS
                && row >= int'(obj.y) && row < int'(obj.y) + TS) begin
            obj_on = 1'b1;
            obj_top = obj.prio;
            obj_colour = obj.colour;
        end
    end
    if (obj_on && (obj_top || !tile_on)) begin
        idx = {1'b1, obj_colour};
    end else if (tile_on) begin
        idx = {1'b0, tile.colour};
    end else begin
        idx = '0;
    end
    return shadow[addr_t'(int'(bus_pkg::PAL_BASE) + int'(idx))][$bits(video_pkg::rgb_t)-1:0];
endfunction

`endif

/* bench/board_video_tb.sv */
// **********************************************************
// Testbench for the board video top level. Writes the tile
// map, the objects and the palette over the CPU bus, checks
// readback and compares every output pixel and the blanking
// against the reference model. Built through project.f.
// **********************************************************
module board_video_tb;

    localparam int H_TOTAL = video_pkg::H_TOTAL_DEF;
    localparam int H_VIS   = video_pkg::H_VIS_DEF;
    localparam int V_TOTAL = video_pkg::V_TOTAL_DEF;
    localparam int V_VIS   = video_pkg::V_VIS_DEF;
    localparam int OBJ_N   = 4;
    localparam int TS      = video_pkg::TILE_SIZE;
    localparam int COLS    = H_VIS / TS;
    localparam int TILE_N  = COLS * (V_VIS / TS);
    localparam int PAL_N   = 2 ** $bits(video_pkg::pal_idx_t);
    localparam int FRAME   = H_TOTAL * V_TOTAL;
    // Frames the tests wait through and bus cycles of the readback test
    localparam int TEST_FRAMES = 16;
    localparam int BUS_CYCLES  = 400;
    localparam int STIM_CYCLES = TEST_FRAMES * FRAME + BUS_CYCLES;
    localparam int CYCLE_LIMIT = 3 * (STIM_CYCLES + 6 * FRAME);

    typedef logic [bus_pkg::ADDR_W-1:0] addr_t;
    typedef logic [bus_pkg::DATA_W-1:0] data_t;

    logic       clk;
    logic       rst;
    addr_t      cpu_addr;
    data_t      cpu_dout;
    logic       cpu_we;
    data_t      cpu_din;
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
    logic       lhbl;
    logic       lvbl;

    string test_name;
    logic  chk_en;
    int    rgb_errs;
    int    word_errs;
    int    timing_errs;
    int    cycle_cnt;
    int    frame_cnt;

    // Screen position tracking from the output blanking
    logic lhbl_q;
    logic lvbl_q;
    logic h_seen;
    logic v_seen;
    int   col;
    int   row;
    int   line_len;
    int   frame_len;
    int   pix_cnt;

    `include "video_ref.svh"

    board_video #(
        .H_TOTAL ( H_TOTAL ),
        .H_VIS   ( H_VIS   ),
        .V_TOTAL ( V_TOTAL ),
        .V_VIS   ( V_VIS   ),
        .OBJ_N   ( OBJ_N   )
    ) u_dut (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .cpu_addr ( cpu_addr ),
        .cpu_dout ( cpu_dout ),
        .cpu_we   ( cpu_we   ),
        .cpu_din  ( cpu_din  ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     ),
        .lhbl     ( lhbl     ),
        .lvbl     ( lvbl     )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_rgb(input string name, input video_pkg::rgb_t exp,
                             input video_pkg::rgb_t act);
        if (act !== exp) begin
            rgb_errs++;
            $display("ERROR %s: expected rgb %03h, actual %03h", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            word_errs++;
            $display("ERROR %s: expected word %04h, actual %04h", name, exp, act);
        end
    endtask

    task automatic report_timing(input string msg);
        timing_errs++;
        $display("%s", msg);
    endtask

    // Inputs change 1 time unit after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic bus_write(input addr_t addr, input data_t data);
        cpu_addr = addr;
        cpu_dout = data;
        cpu_we   = 1'b1;
        shadow_write(addr, data);
        next_cycle();
        cpu_we = 1'b0;
    endtask

    task automatic bus_read_check(input addr_t addr);
        cpu_addr = addr;
        cpu_we   = 1'b0;
        next_cycle();
        check_word($sformatf("%s @%02h", test_name, addr), shadow[addr], cpu_din);
    endtask

    task automatic write_read(input addr_t addr);
        bus_write(addr, data_t'($urandom));
        bus_read_check(addr);
    endtask

    task automatic wait_vblank();
        @(negedge lvbl);
        next_cycle();
    endtask

    function automatic data_t make_obj(input int x, input int y, input int colour,
                                       input logic en, input logic prio);
        bus_pkg::obj_entry_t o;
        o = '0;
        o.x = 5'(x);
        o.y = 4'(y);
        o.colour = 4'(colour);
        o.en = en;
        o.prio = prio;
        return data_t'(o);
    endfunction

    task automatic fill_tiles(input logic random_fill);
        for (int t = 0; t < TILE_N; t++) begin
            bus_write(bus_pkg::TILE_BASE + addr_t'(t), random_fill ? data_t'($urandom) : '0);
        end
    endtask

    task automatic load_palette();
        for (int p = 0; p < PAL_N; p++) begin
            bus_write(bus_pkg::PAL_BASE + addr_t'(p), data_t'($urandom));
        end
    endtask

    // Pixel and blanking compare on the falling edge
    always @(negedge clk) begin
        if (rst !== 1'b0) begin
            lhbl_q = 1'b0;
            lvbl_q = 1'b0;
            h_seen = 1'b0;
            v_seen = 1'b0;
            col = 0;
            row = -1;
            line_len = 0;
            frame_len = 0;
            pix_cnt = 0;
        end else begin
            line_len++;
            frame_len++;
            if (lvbl && !lvbl_q) begin
                if (v_seen && frame_len != FRAME) begin
                    report_timing($sformatf("Frame period was %0d clocks instead of %0d",
                                            frame_len, FRAME));
                end
                v_seen = 1'b1;
                frame_len = 0;
                row = -1;
                pix_cnt = 0;
            end
            if (!lvbl && lvbl_q) begin
                frame_cnt++;
                if (pix_cnt != H_VIS * V_VIS) begin
                    report_timing($sformatf("Frame had %0d visible pixels instead of %0d",
                                            pix_cnt, H_VIS * V_VIS));
                end
            end
            if (lhbl && !lhbl_q) begin
                if (h_seen && line_len != H_TOTAL) begin
                    report_timing($sformatf("Line period was %0d clocks instead of %0d",
                                            line_len, H_TOTAL));
                end
                h_seen = 1'b1;
                line_len = 0;
                col = 0;
                if (lvbl) begin
                    row++;
                end
            end
            if (!lhbl && lhbl_q && lvbl_q && col != H_VIS) begin
                report_timing($sformatf("Line %0d lost its blanking edge after %0d pixels",
                                        row, col));
            end
            if (lhbl && lvbl) begin
                if (chk_en) begin
                    check_rgb($sformatf("%s pixel (%0d,%0d)", test_name, col, row),
                              expected_rgb(col, row), {red, green, blue});
                end
                col++;
                pix_cnt++;
            end else begin
                check_rgb("blanking", '0, {red, green, blue});
            end
            lhbl_q = lhbl;
            lvbl_q = lvbl;
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d clocks, the tests did not finish", cycle_cnt);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int seed;
        int x;
        int y;
        int c0;
        seed = $urandom(64);
        rst = 1'b1;
        cpu_addr = '0;
        cpu_dout = '0;
        cpu_we = 1'b0;
        chk_en = 1'b0;
        test_name = "reset";
        rgb_errs = 0;
        word_errs = 0;
        timing_errs = 0;
        frame_cnt = 0;
        shadow_clear();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check_word("reset_din", '0, cpu_din);

        // Blanking stays low through the pipeline after reset
        for (int k = 0; k < video_pkg::PIPE_DEPTH; k++) begin
            if (lhbl || lvbl) begin
                report_timing($sformatf("Blanking rose %0d clocks after reset instead of %0d",
                                        k, video_pkg::PIPE_DEPTH));
            end
            next_cycle();
        end
        if (!lhbl || !lvbl) begin
            report_timing("Blanking was still low once the pipeline had filled after reset");
        end

        // Cleared map and objects show palette entry 0
        test_name = "reset_clear";
        wait_vblank();
        fill_tiles(1'b0);
        load_palette();
        chk_en = 1'b1;
        repeat (2) wait_vblank();

        test_name = "readback";
        chk_en = 1'b0;
        for (int t = 0; t < TILE_N; t++) begin
            write_read(bus_pkg::TILE_BASE + addr_t'(t));
        end
        for (int i = 0; i < OBJ_N; i++) begin
            write_read(bus_pkg::OBJ_BASE + addr_t'(i));
        end
        repeat (8) write_read(bus_pkg::PAL_BASE + addr_t'($urandom % PAL_N));
        write_read(bus_pkg::TILE_BASE + addr_t'(TILE_N));
        write_read(bus_pkg::OBJ_BASE - 8'd1);
        write_read(bus_pkg::OBJ_BASE + addr_t'(OBJ_N));
        write_read(bus_pkg::PAL_BASE - 8'd1);
        write_read(bus_pkg::PAL_BASE + addr_t'(PAL_N));
        write_read(8'hff);
        // Random contents from readback get one checked frame
        wait_vblank();
        chk_en = 1'b1;
        wait_vblank();

        test_name = "tile_quadrants";
        for (int i = 0; i < OBJ_N; i++) begin
            bus_write(bus_pkg::OBJ_BASE + addr_t'(i), '0);
        end
        repeat (2) begin
            fill_tiles(1'b1);
            wait_vblank();
        end

        // Object 0 stays disabled while the others are mostly enabled
        test_name = "objects_over_tiles";
        repeat (3) begin
            fill_tiles(1'b1);
            for (int i = 0; i < OBJ_N; i++) begin
                bus_write(bus_pkg::OBJ_BASE + addr_t'(i),
                          make_obj($urandom % H_VIS, $urandom % V_VIS, $urandom,
                                   (i != 0) && ($urandom % 4 != 0), 1'($urandom % 2)));
            end
            wait_vblank();
        end

        test_name = "object_overlap";
        repeat (2) begin
            fill_tiles(1'b0);
            x = $urandom % (H_VIS - TS);
            y = $urandom % (V_VIS - TS);
            c0 = $urandom % 16;
            bus_write(bus_pkg::OBJ_BASE, make_obj(x + 2, y + 1, c0, 1'b1, 1'b1));
            bus_write(bus_pkg::OBJ_BASE + 8'd1, make_obj(x, y, (c0 + 1) % 16, 1'b1, 1'b1));
            for (int i = 2; i < OBJ_N; i++) begin
                bus_write(bus_pkg::OBJ_BASE + addr_t'(i), '0);
            end
            wait_vblank();
        end

        // New palette lands in vertical blanking
        test_name = "palette_change";
        repeat (2) begin
            load_palette();
            wait_vblank();
        end

        if (frame_cnt == 0) begin
            report_timing("No complete frame was seen on the blanking outputs");
        end
        $display("Errors: rgb %0d, readback %0d, timing %0d", rgb_errs, word_errs,
                 timing_errs);
        if (rgb_errs + word_errs + timing_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* verilog/board_video.sv */
// **********************************************************
// Video half of the board. Decodes the CPU bus into the
// tile, object and palette regions, muxes the readback
// and wires the raster, both layers and the mixer.
// Raster sizes and the object count are set here.
// **********************************************************
module board_video #(
    parameter int H_TOTAL = video_pkg::H_TOTAL_DEF,
    parameter int H_VIS   = video_pkg::H_VIS_DEF,
    parameter int V_TOTAL = video_pkg::V_TOTAL_DEF,
    parameter int V_VIS   = video_pkg::V_VIS_DEF,
    parameter int OBJ_N   = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [bus_pkg::ADDR_W-1:0] cpu_addr,
    input  logic [bus_pkg::DATA_W-1:0] cpu_dout,
    input  logic                       cpu_we,
    output logic [bus_pkg::DATA_W-1:0] cpu_din,
    output logic [3:0]                 red,
    output logic [3:0]                 green,
    output logic [3:0]                 blue,
    output logic                       lhbl,
    output logic                       lvbl
);

    localparam int TS         = video_pkg::TILE_SIZE;
    localparam int TILE_DEPTH = (H_VIS / TS) * (V_VIS / TS);
    localparam int TILE_AW    = (TILE_DEPTH > 1) ? $clog2(TILE_DEPTH) : 1;
    localparam int OBJ_AW     = (OBJ_N > 1) ? $clog2(OBJ_N) : 1;
    localparam int PAL_AW     = $bits(video_pkg::pal_idx_t);

    logic [bus_pkg::ADDR_W-1:0] tile_off;
    logic [bus_pkg::ADDR_W-1:0] obj_off;
    logic [bus_pkg::ADDR_W-1:0] pal_off;
    logic                       tile_hit;
    logic                       obj_hit;
    logic                       pal_hit;
    logic                       tile_we;
    logic                       obj_we;
    logic                       pal_we;
    logic                       rd_tile;
    logic                       rd_obj;
    logic                       rd_pal;
    logic [video_pkg::HCNT_W-1:0] hcnt;
    logic [video_pkg::VCNT_W-1:0] vcnt;
    logic                       vid_lhbl;
    logic                       vid_lvbl;
    logic [3:0]                 tile_pix;
    logic                       tile_opaque;
    logic [3:0]                 obj_pix;
    logic                       obj_opaque;
    logic                       obj_prio;
    bus_pkg::tile_entry_t       tile_wdata;
    bus_pkg::tile_entry_t       tile_rdata;
    bus_pkg::obj_entry_t        obj_rdata;
    video_pkg::rgb_t            pal_wdata;
    video_pkg::rgb_t            pal_rdata;

    // Offsets wrap below a base, so one compare per region
    always_comb begin
        tile_off = cpu_addr - bus_pkg::TILE_BASE;
        obj_off  = cpu_addr - bus_pkg::OBJ_BASE;
        pal_off  = cpu_addr - bus_pkg::PAL_BASE;
        tile_hit = int'(tile_off) < TILE_DEPTH;
        obj_hit  = int'(obj_off) < OBJ_N;
        pal_hit  = int'(pal_off) < video_pkg::PAL_DEPTH;
    end

    assign tile_we    = cpu_we && tile_hit;
    assign obj_we     = cpu_we && obj_hit;
    assign pal_we     = cpu_we && pal_hit;
    assign tile_wdata = cpu_dout[$bits(bus_pkg::tile_entry_t)-1:0];
    assign pal_wdata  = cpu_dout[$bits(video_pkg::rgb_t)-1:0];

    // Region select lines up with the registered RAM reads
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_tile <= 1'b0;
            rd_obj  <= 1'b0;
            rd_pal  <= 1'b0;
        end else begin
            rd_tile <= tile_hit;
            rd_obj  <= obj_hit;
            rd_pal  <= pal_hit;
        end
    end

    always_comb begin
        cpu_din = '0;
        if (rd_tile) begin
            cpu_din[$bits(tile_rdata)-1:0] = tile_rdata;
        end else if (rd_obj) begin
            cpu_din[$bits(obj_rdata)-1:0] = obj_rdata;
        end else if (rd_pal) begin
            cpu_din[$bits(pal_rdata)-1:0] = pal_rdata;
        end
    end

    vid_timing #(
        .H_TOTAL ( H_TOTAL ),
        .H_VIS   ( H_VIS   ),
        .V_TOTAL ( V_TOTAL ),
        .V_VIS   ( V_VIS   )
    ) u_timing (
        .clk  ( clk      ),
        .rst  ( rst      ),
        .hcnt ( hcnt     ),
        .vcnt ( vcnt     ),
        .lhbl ( vid_lhbl ),
        .lvbl ( vid_lvbl )
    );

    tile_layer #(
        .H_VIS ( H_VIS ),
        .V_VIS ( V_VIS )
    ) u_tile (
        .clk         ( clk                    ),
        .rst         ( rst                    ),
        .hcnt        ( hcnt                   ),
        .vcnt        ( vcnt                   ),
        .cpu_addr    ( tile_off[TILE_AW-1:0]  ),
        .cpu_dout    ( tile_wdata             ),
        .tile_we     ( tile_we                ),
        .cpu_rdata   ( tile_rdata             ),
        .tile_pix    ( tile_pix               ),
        .tile_opaque ( tile_opaque            )
    );

    obj_layer #(
        .OBJ_N ( OBJ_N )
    ) u_obj (
        .clk        ( clk                  ),
        .rst        ( rst                  ),
        .hcnt       ( hcnt                 ),
        .vcnt       ( vcnt                 ),
        .cpu_addr   ( obj_off[OBJ_AW-1:0]  ),
        .cpu_dout   ( cpu_dout             ),
        .obj_we     ( obj_we               ),
        .cpu_rdata  ( obj_rdata            ),
        .obj_pix    ( obj_pix              ),
        .obj_opaque ( obj_opaque           ),
        .obj_prio   ( obj_prio             )
    );

    pix_mixer u_mixer (
        .clk         ( clk                  ),
        .rst         ( rst                  ),
        .lhbl        ( vid_lhbl             ),
        .lvbl        ( vid_lvbl             ),
        .tile_pix    ( tile_pix             ),
        .tile_opaque ( tile_opaque          ),
        .obj_pix     ( obj_pix              ),
        .obj_opaque  ( obj_opaque           ),
        .obj_prio    ( obj_prio             ),
        .cpu_addr    ( pal_off[PAL_AW-1:0]  ),
        .cpu_dout    ( pal_wdata            ),
        .pal_we      ( pal_we               ),
        .cpu_rdata   ( pal_rdata            ),
        .red         ( red                  ),
        .green       ( green                ),
        .blue        ( blue                 ),
        .lhbl_out    ( lhbl                 ),
        .lvbl_out    ( lvbl                 )
    );

endmodule

/* verilog/pix_mixer.sv */
// **********************************************************
// Pixel mixer. Picks the tile or object colour by priority,
// reads the palette and blanks the result. RGB and the
// delayed blanking come PIPE_DEPTH clocks after the
// counters.
// **********************************************************
module pix_mixer (
    input  logic                clk,
    input  logic                rst,
    input  logic                lhbl,
    input  logic                lvbl,
    input  logic [3:0]          tile_pix,
    input  logic                tile_opaque,
    input  logic [3:0]          obj_pix,
    input  logic                obj_opaque,
    input  logic                obj_prio,
    input  video_pkg::pal_idx_t cpu_addr,
    input  video_pkg::rgb_t     cpu_dout,
    input  logic                pal_we,
    output video_pkg::rgb_t     cpu_rdata,
    output logic [3:0]          red,
    output logic [3:0]          green,
    output logic [3:0]          blue,
    output logic                lhbl_out,
    output logic                lvbl_out
);

    localparam int PD = video_pkg::PIPE_DEPTH;

    video_pkg::pal_idx_t pal_idx;
    video_pkg::rgb_t     pal_rgb;
    logic [PD-1:0]       lhbl_dly;
    logic [PD-1:0]       lvbl_dly;
    logic                vis;

    always_comb begin
        if (obj_opaque && (obj_prio || !tile_opaque)) begin
            pal_idx = {1'b1, obj_pix};
        end else if (tile_opaque) begin
            pal_idx = {1'b0, tile_pix};
        end else begin
            pal_idx = '0;
        end
    end

    gfx_ram #(
        .word_t ( video_pkg::rgb_t     ),
        .DEPTH  ( video_pkg::PAL_DEPTH )
    ) u_pal (
        .clk       ( clk       ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_wdata ( cpu_dout  ),
        .cpu_we    ( pal_we    ),
        .cpu_rdata ( cpu_rdata ),
        .vid_addr  ( pal_idx   ),
        .vid_rdata ( pal_rgb   )
    );

    // Blanking follows the whole pixel pipeline
    always_ff @(posedge clk) begin
        if (rst) begin
            lhbl_dly <= '0;
            lvbl_dly <= '0;
        end else begin
            lhbl_dly <= {lhbl_dly[PD-2:0], lhbl};
            lvbl_dly <= {lvbl_dly[PD-2:0], lvbl};
        end
    end

    assign lhbl_out = lhbl_dly[PD-1];
    assign lvbl_out = lvbl_dly[PD-1];
    assign vis      = lhbl_out && lvbl_out;
    assign red      = vis ? pal_rgb.r : '0;
    assign green    = vis ? pal_rgb.g : '0;
    assign blue     = vis ? pal_rgb.b : '0;

    // Raster blanking seen PD clocks ago must leave the output black
    a_blank_black: assert property (@(posedge clk) disable iff (rst)
        (!$past(lhbl, PD) || !$past(lvbl, PD)) |-> {red, green, blue} == '0)
        else $error("RGB not black during blanking");

endmodule

/* verilog/obj_layer.sv */
// **********************************************************
// Object layer. Keeps OBJ_N object registers and tests the
// current pixel against all of them in parallel. The
// lowest numbered enabled hit wins. Output lines up with
// the tile layer, two clocks after the counters.
// **********************************************************
module obj_layer #(
    parameter int OBJ_N = 4,
    localparam int AW = (OBJ_N > 1) ? $clog2(OBJ_N) : 1
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [video_pkg::HCNT_W-1:0] hcnt,
    input  logic [video_pkg::VCNT_W-1:0] vcnt,
    input  logic [AW-1:0]                 cpu_addr,
    input  bus_pkg::obj_entry_t           cpu_dout,
    input  logic                          obj_we,
    output bus_pkg::obj_entry_t           cpu_rdata,
    output logic [3:0]                    obj_pix,
    output logic                          obj_opaque,
    output logic                          obj_prio
);

    localparam int TS = video_pkg::TILE_SIZE;

    bus_pkg::obj_entry_t objs [OBJ_N];
    logic                hit_any;
    logic [3:0]          hit_pix;
    logic                hit_prio;
    logic                hit_any_q;
    logic [3:0]          hit_pix_q;
    logic                hit_prio_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < OBJ_N; i++) begin
                objs[i] <= '0;
            end
        end else if (obj_we) begin
            objs[cpu_addr] <= cpu_dout;
        end
    end

    always_ff @(posedge clk) begin
        cpu_rdata <= objs[cpu_addr];
    end

    // Hit test, walked from the top so the lowest index stays
    always_comb begin
        int dx;
        int dy;
        hit_any  = 1'b0;
        hit_pix  = '0;
        hit_prio = 1'b0;
        for (int i = OBJ_N - 1; i >= 0; i--) begin
            dx = int'(hcnt) - int'(objs[i].x);
            dy = int'(vcnt) - int'(objs[i].y);
            if (objs[i].en && dx >= 0 && dx < TS && dy >= 0 && dy < TS) begin
                hit_any  = 1'b1;
                hit_pix  = objs[i].colour;
                hit_prio = objs[i].prio;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hit_any_q  <= 1'b0;
            hit_pix_q  <= '0;
            hit_prio_q <= 1'b0;
            obj_opaque <= 1'b0;
            obj_pix    <= '0;
            obj_prio   <= 1'b0;
        end else begin
            hit_any_q  <= hit_any;
            hit_pix_q  <= hit_pix;
            hit_prio_q <= hit_prio;
            // Extra stage matches the tile map read
            obj_opaque <= hit_any_q;
            obj_pix    <= hit_pix_q;
            obj_prio   <= hit_prio_q;
        end
    end

endmodule

/* verilog/tile_layer.sv */
// **********************************************************
// Tile layer. Looks the pixel's tile up in the map and
// picks the quadrant bit from its opacity mask. The tile
// pixel is registered two clocks after the counters.
// **********************************************************
module tile_layer #(
    parameter int H_VIS = video_pkg::H_VIS_DEF,
    parameter int V_VIS = video_pkg::V_VIS_DEF,
    localparam int TS    = video_pkg::TILE_SIZE,
    localparam int COLS  = H_VIS / TS,
    localparam int DEPTH = COLS * (V_VIS / TS),
    localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [video_pkg::HCNT_W-1:0] hcnt,
    input  logic [video_pkg::VCNT_W-1:0] vcnt,
    input  logic [AW-1:0]                 cpu_addr,
    input  bus_pkg::tile_entry_t          cpu_dout,
    input  logic                          tile_we,
    output bus_pkg::tile_entry_t          cpu_rdata,
    output logic [3:0]                    tile_pix,
    output logic                          tile_opaque
);

    logic                 on_scr;
    logic [1:0]           quad;
    logic [AW-1:0]        map_addr;
    logic                 on_scr_q;
    logic [1:0]           quad_q;
    bus_pkg::tile_entry_t map_entry;

    always_comb begin
        on_scr  = (int'(hcnt) < H_VIS) && (int'(vcnt) < V_VIS);
        // Quadrant number matches the mask bit order
        quad[1] = (int'(vcnt) % TS) >= TS / 2;
        quad[0] = (int'(hcnt) % TS) >= TS / 2;
        map_addr = on_scr ? AW'((int'(vcnt) / TS) * COLS + int'(hcnt) / TS) : '0;
    end

    gfx_ram #(
        .word_t ( bus_pkg::tile_entry_t ),
        .DEPTH  ( DEPTH                 )
    ) u_map (
        .clk       ( clk       ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_wdata ( cpu_dout  ),
        .cpu_we    ( tile_we   ),
        .cpu_rdata ( cpu_rdata ),
        .vid_addr  ( map_addr  ),
        .vid_rdata ( map_entry )
    );

    // Quadrant and visibility ride along with the map read
    always_ff @(posedge clk) begin
        if (rst) begin
            on_scr_q <= 1'b0;
            quad_q   <= '0;
        end else begin
            on_scr_q <= on_scr;
            quad_q   <= quad;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tile_pix    <= '0;
            tile_opaque <= 1'b0;
        end else begin
            tile_pix    <= on_scr_q ? map_entry.colour : '0;
            tile_opaque <= on_scr_q && map_entry.mask[quad_q];
        end
    end

endmodule

/* verilog/vid_timing.sv */
// **********************************************************
// Raster generator. Free-running horizontal and vertical
// counters with the blanking levels decoded from them.
// Blanking levels are high on the visible area.
// **********************************************************
module vid_timing #(
    parameter int H_TOTAL = video_pkg::H_TOTAL_DEF,
    parameter int H_VIS   = video_pkg::H_VIS_DEF,
    parameter int V_TOTAL = video_pkg::V_TOTAL_DEF,
    parameter int V_VIS   = video_pkg::V_VIS_DEF
) (
    input  logic                          clk,
    input  logic                          rst,
    output logic [video_pkg::HCNT_W-1:0] hcnt,
    output logic [video_pkg::VCNT_W-1:0] vcnt,
    output logic                          lhbl,
    output logic                          lvbl
);

    logic h_last;
    logic v_last;

    assign h_last = int'(hcnt) == H_TOTAL - 1;
    assign v_last = int'(vcnt) == V_TOTAL - 1;

    always_ff @(posedge clk) begin
        if (rst) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (h_last) begin
            hcnt <= '0;
            // Line ends, step the row
            vcnt <= v_last ? '0 : vcnt + 1'b1;
        end else begin
            hcnt <= hcnt + 1'b1;
        end
    end

    assign lhbl = int'(hcnt) < H_VIS;
    assign lvbl = int'(vcnt) < V_VIS;

    a_hcnt_range: assert property (@(posedge clk) disable iff (rst) int'(hcnt) < H_TOTAL)
        else $error("hcnt past H_TOTAL");

endmodule

/* verilog/gfx_ram.sv */
// **********************************************************
// Dual-port graphics RAM. The CPU port writes and reads
// back, the video port only reads. Both reads have one
// clock of latency. The word type is set per instance.
// **********************************************************
module gfx_ram #(
    parameter type word_t = logic [15:0],
    parameter int DEPTH = 16,
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic          clk,
    input  logic [AW-1:0] cpu_addr,
    input  word_t         cpu_wdata,
    input  logic          cpu_we,
    output word_t         cpu_rdata,
    input  logic [AW-1:0] vid_addr,
    output word_t         vid_rdata
);

    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_wdata;
        end
        cpu_rdata <= mem[cpu_addr];
    end

    always_ff @(posedge clk) begin
        vid_rdata <= mem[vid_addr];
    end

    // The top level decode must keep writes inside the array
    a_wr_in_range: assert property (@(posedge clk) cpu_we |-> int'(cpu_addr) < DEPTH)
        else $error("gfx_ram write outside DEPTH");

endmodule

/* verilog/bus_pkg.sv */
// **********************************************************
// CPU side definitions: bus widths, the address map and
// the layout of the tile and object words as the CPU
// writes them.
// **********************************************************
package bus_pkg;

    localparam int ADDR_W = 8;
    localparam int DATA_W = 16;

    // Each region spans 64 addresses, the rest is unmapped
    localparam logic [ADDR_W-1:0] TILE_BASE = 8'h00;
    localparam logic [ADDR_W-1:0] OBJ_BASE  = 8'h40;
    localparam logic [ADDR_W-1:0] PAL_BASE  = 8'h80;

    // Tile map word, data bits 7:0
    typedef struct packed {
        logic [3:0] colour;
        // Bit 2 * lower half + right half, set when opaque
        logic [3:0] mask;
    } tile_entry_t;

    // Object word, x in the low bits
    typedef struct packed {
        logic       spare;
        logic       prio;
        logic       en;
        logic [3:0] colour;
        logic [3:0] y;
        logic [4:0] x;
    } obj_entry_t;

endpackage

/* verilog/video_pkg.sv */
// **********************************************************
// Raster defaults, counter widths and the pixel types
// shared by the layers, the mixer and the bench. Files use
// these through scoped names.
// **********************************************************
package video_pkg;

    // Tiny screen, one pixel per clock
    localparam int H_TOTAL_DEF = 24;
    localparam int H_VIS_DEF   = 16;
    localparam int V_TOTAL_DEF = 12;
    localparam int V_VIS_DEF   = 8;

    localparam int HCNT_W = 5;
    localparam int VCNT_W = 4;

    // Clocks from the counters to RGB
    localparam int PIPE_DEPTH = 3;

    // Tiles and objects are both this many pixels square
    localparam int TILE_SIZE = 4;

    // Top bit picks the object half of the palette
    typedef logic [4:0] pal_idx_t;

    localparam int PAL_DEPTH = 2 ** $bits(pal_idx_t);

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

endpackage
